/* phy_mgmt_pkg.sv */
package phy_mgmt_pkg;

    // clause-22 write frame layout
    localparam int MDIO_PREAMBLE_BITS = 32;
    localparam int MDIO_FRAME_BITS = 64;

    localparam logic [1:0] MDIO_START = 2'b01;
    localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
    // write turnaround is driven by the master as 1 then 0
    localparam logic [1:0] MDIO_TA_WRITE = 2'b10;

    typedef logic [4:0] mdio_reg_addr_t;
    typedef logic [4:0] mdio_phy_addr_t;
    typedef logic [15:0] mdio_data_t;

    // indirect access to the extended register space
    localparam mdio_reg_addr_t REG_REGCR = 5'h0D;
    localparam mdio_reg_addr_t REG_ADDAR = 5'h0E;

    // devad 0x1f, address function
    localparam mdio_data_t REGCR_ADDR_MODE = 16'h001F;
    // devad 0x1f, data function without post-increment
    localparam mdio_data_t REGCR_DATA_MODE = 16'h401F;

    // one extended write, register address in the upper half
    typedef struct packed {
        mdio_data_t addr;
        mdio_data_t data;
    } ext_write_t;

    localparam int EXT_WRITE_COUNT = 3;

    // startup writes in issue order
    localparam ext_write_t EXT_WRITES [EXT_WRITE_COUNT] = '{
        // CFG4: SGMII autonegotiation timer 11 ms
        '{addr: 16'h0031, data: 16'h0070},
        // SGMIICTL1: SGMII clock output enable
        '{addr: 16'h00D3, data: 16'h4000},
        // 10M_SGMII_CFG: allow 10 Mb/s over SGMII
        '{addr: 16'h016F, data: 16'h0015}
    };

endpackage

/* debounce_switch.sv */
`timescale 1ns/1ps

module debounce_switch #(
    parameter int DEBOUNCE_WIDTH = 9,
    parameter int DEBOUNCE_DEPTH = 4,
    parameter int DEBOUNCE_RATE = 125000
) (
    input  logic                      clk_125mhz_int,
    input  logic                      rst_125mhz_int,
    input  logic [DEBOUNCE_WIDTH-1:0] sw_raw_i,
    output logic [DEBOUNCE_WIDTH-1:0] sw_clean_o
);

    localparam int RATE_W = $clog2(DEBOUNCE_RATE + 1);

    logic [RATE_W-1:0] rate_cnt;
    logic              sample_tick;

    // sample history per input, newest sample in bit 0
    logic [DEBOUNCE_WIDTH-1:0][DEBOUNCE_DEPTH-1:0] hist;
    logic [DEBOUNCE_WIDTH-1:0][DEBOUNCE_DEPTH-1:0] next_hist;

    assign sample_tick = (rate_cnt == RATE_W'(DEBOUNCE_RATE - 1));

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            rate_cnt <= '0;
        end else if (sample_tick) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < DEBOUNCE_WIDTH; i++) begin
            next_hist[i] = (hist[i] << 1) | DEBOUNCE_DEPTH'(sw_raw_i[i]);
        end
    end

    // output follows only a full run of agreeing samples
    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            hist <= '0;
            sw_clean_o <= '0;
        end else if (sample_tick) begin
            hist <= next_hist;
            for (int i = 0; i < DEBOUNCE_WIDTH; i++) begin
                if (&next_hist[i]) begin
                    sw_clean_o[i] <= 1'b1;
                end else if (~|next_hist[i]) begin
                    sw_clean_o[i] <= 1'b0;
                end
            end
        end
    end

    a_change_after_tick: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        $changed(sw_clean_o) |-> $past(sample_tick)
    );

endmodule

/* phy_ext_reg_seq.sv */
`timescale 1ns/1ps

module phy_ext_reg_seq import phy_mgmt_pkg::*; #(
    parameter int PHY_ADDR = 3,
    parameter int INIT_DELAY = 1048575
) (
    input  logic           clk_125mhz_int,
    input  logic           rst_125mhz_int,
    output mdio_phy_addr_t cmd_phy_addr_o,
    output mdio_reg_addr_t cmd_reg_addr_o,
    output mdio_data_t     cmd_data_o,
    output logic           cmd_valid_o,
    input  logic           cmd_ready_i,
    output logic           init_done_o
);

    localparam int DLY_W = $clog2(INIT_DELAY + 1);
    localparam int ENTRY_W = $clog2(EXT_WRITE_COUNT);

    typedef enum logic [1:0] {
        ST_DELAY,
        ST_SEND,
        ST_WAIT,
        ST_FINISH
    } seq_state_t;

    seq_state_t         state;
    logic [DLY_W-1:0]   delay_cnt;
    logic [ENTRY_W-1:0] entry_idx;
    logic [1:0]         step_idx;
    ext_write_t         cur_write;
    logic               last_cmd;

    assign cmd_phy_addr_o = mdio_phy_addr_t'(PHY_ADDR);
    assign last_cmd = (entry_idx == ENTRY_W'(EXT_WRITE_COUNT - 1)) && (step_idx == 2'd3);

    // four commands per extended write
    always_comb begin
        cur_write = EXT_WRITES[entry_idx];
        case (step_idx)
            2'd0: begin
                cmd_reg_addr_o = REG_REGCR;
                cmd_data_o = REGCR_ADDR_MODE;
            end
            2'd1: begin
                cmd_reg_addr_o = REG_ADDAR;
                cmd_data_o = cur_write.addr;
            end
            2'd2: begin
                cmd_reg_addr_o = REG_REGCR;
                cmd_data_o = REGCR_DATA_MODE;
            end
            default: begin
                cmd_reg_addr_o = REG_ADDAR;
                cmd_data_o = cur_write.data;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state <= ST_DELAY;
            delay_cnt <= DLY_W'(INIT_DELAY - 1);
            entry_idx <= '0;
            step_idx <= '0;
            cmd_valid_o <= 1'b0;
            init_done_o <= 1'b0;
        end else begin
            case (state)
                ST_DELAY: begin
                    if (delay_cnt == '0) begin
                        cmd_valid_o <= 1'b1;
                        state <= ST_SEND;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                ST_SEND: begin
                    // hold everything until the master takes it
                    if (cmd_ready_i) begin
                        cmd_valid_o <= 1'b0;
                        if (last_cmd) begin
                            state <= ST_FINISH;
                        end else begin
                            step_idx <= step_idx + 1'b1;
                            if (step_idx == 2'd3) begin
                                entry_idx <= entry_idx + 1'b1;
                            end
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    // ready is low while the frame is on the wire
                    if (cmd_ready_i) begin
                        cmd_valid_o <= 1'b1;
                        state <= ST_SEND;
                    end
                end
                default: begin
                    if (cmd_ready_i) begin
                        init_done_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        cmd_valid_o && !cmd_ready_i |=>
            cmd_valid_o && $stable(cmd_reg_addr_o) && $stable(cmd_data_o)
            && $stable(cmd_phy_addr_o)
    );

endmodule

/* mdio_master.sv */
`timescale 1ns/1ps

module mdio_master import phy_mgmt_pkg::*; #(
    parameter int PRESCALE = 3
) (
    input  logic           clk_125mhz_int,
    input  logic           rst_125mhz_int,
    input  mdio_phy_addr_t cmd_phy_addr_i,
    input  mdio_reg_addr_t cmd_reg_addr_i,
    input  mdio_data_t     cmd_data_i,
    input  logic           cmd_valid_i,
    output logic           cmd_ready_o,
    output logic           mdc_o,
    output logic           mdio_o,
    output logic           mdio_t_o
);

    localparam int PRE_W = $clog2(PRESCALE + 2);
    localparam int BIT_W = $clog2(MDIO_FRAME_BITS);

    logic                       busy;
    logic [PRE_W-1:0]           pre_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic [MDIO_FRAME_BITS-1:0] shift_reg;
    logic [MDIO_FRAME_BITS-1:0] frame;
    logic                       accept;
    logic                       phase_end;

    assign cmd_ready_o = !busy;
    assign accept = cmd_valid_i && !busy;
    assign phase_end = (pre_cnt == PRE_W'(PRESCALE));

    // frame goes out MSB first
    assign mdio_o = shift_reg[MDIO_FRAME_BITS-1];

    assign frame = {
        {MDIO_PREAMBLE_BITS{1'b1}},
        MDIO_START,
        MDIO_OP_WRITE,
        cmd_phy_addr_i,
        cmd_reg_addr_i,
        MDIO_TA_WRITE,
        cmd_data_i
    };

    // frame payload
    always_ff @(posedge clk_125mhz_int) begin
        if (accept) begin
            shift_reg <= frame;
        end else if (busy && phase_end && mdc_o) begin
            // next bit after the falling edge
            shift_reg <= shift_reg << 1;
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy <= 1'b0;
            pre_cnt <= '0;
            bit_cnt <= '0;
            mdc_o <= 1'b0;
            mdio_t_o <= 1'b1;
        end else if (!busy) begin
            if (cmd_valid_i) begin
                busy <= 1'b1;
                pre_cnt <= '0;
                bit_cnt <= '0;
                mdc_o <= 1'b0;
                mdio_t_o <= 1'b0;
            end
        end else if (phase_end) begin
            pre_cnt <= '0;
            mdc_o <= !mdc_o;
            if (mdc_o) begin
                // falling edge closes one mdc period
                if (bit_cnt == BIT_W'(MDIO_FRAME_BITS - 1)) begin
                    busy <= 1'b0;
                    mdio_t_o <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    a_drive_only_in_frame: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        !mdio_t_o == !cmd_ready_o
    );

    // idle bus keeps mdc parked low
    a_mdc_low_when_idle: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        cmd_ready_o |-> !mdc_o
    );

endmodule

/* phy_mgmt_top.sv */
`timescale 1ns/1ps

module phy_mgmt_top import phy_mgmt_pkg::*; #(
    parameter int PRESCALE = 3,
    parameter int PHY_ADDR = 3,
    parameter int INIT_DELAY = 1048575,
    parameter int DEBOUNCE_RATE = 125000,
    parameter int DEBOUNCE_DEPTH = 4,
    parameter int DEBOUNCE_WIDTH = 9
) (
    input  logic       clk_125mhz_int,
    input  logic       rst_125mhz_int,
    input  logic [4:0] btn_i,
    input  logic [3:0] sw_i,
    output logic [4:0] btn_o,
    output logic [3:0] sw_o,
    output logic       mdc_o,
    output logic       mdio_o,
    output logic       mdio_t_o,
    output logic       phy_init_done_o
);

    mdio_phy_addr_t cmd_phy_addr;
    mdio_reg_addr_t cmd_reg_addr;
    mdio_data_t     cmd_data;
    logic           cmd_valid;
    logic           cmd_ready;

    // buttons in the upper bits, switches below
    debounce_switch #(
        .DEBOUNCE_WIDTH(DEBOUNCE_WIDTH),
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH),
        .DEBOUNCE_RATE(DEBOUNCE_RATE)
    ) debounce_switch_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .sw_raw_i({btn_i, sw_i}),
        .sw_clean_o({btn_o, sw_o})
    );

    phy_ext_reg_seq #(
        .PHY_ADDR(PHY_ADDR),
        .INIT_DELAY(INIT_DELAY)
    ) phy_ext_reg_seq_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd_phy_addr_o(cmd_phy_addr),
        .cmd_reg_addr_o(cmd_reg_addr),
        .cmd_data_o(cmd_data),
        .cmd_valid_o(cmd_valid),
        .cmd_ready_i(cmd_ready),
        .init_done_o(phy_init_done_o)
    );

    mdio_master #(
        .PRESCALE(PRESCALE)
    ) mdio_master_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd_phy_addr_i(cmd_phy_addr),
        .cmd_reg_addr_i(cmd_reg_addr),
        .cmd_data_i(cmd_data),
        .cmd_valid_i(cmd_valid),
        .cmd_ready_o(cmd_ready),
        .mdc_o(mdc_o),
        .mdio_o(mdio_o),
        .mdio_t_o(mdio_t_o)
    );

endmodule

/* tb_phy_mgmt.sv */
`timescale 1ns/1ps

module tb_phy_mgmt import phy_mgmt_pkg::*; ();

    localparam int PRESCALE = 3;
    localparam int PHY_ADDR = 3;
    localparam int INIT_DELAY = 40;
    localparam int DEBOUNCE_RATE = 8;
    localparam int DEBOUNCE_DEPTH = 4;
    localparam int DEBOUNCE_WIDTH = 9;
    localparam int HOLD_CYCLES = 2 * DEBOUNCE_DEPTH * DEBOUNCE_RATE;
    localparam int DONE_TIMEOUT = 20000;

    logic        clk_125mhz_int;
    logic        rst_125mhz_int;
    logic [4:0]  btn;
    logic [3:0]  sw;
    logic [4:0]  btn_db;
    logic [3:0]  sw_db;
    logic        mdc;
    logic        mdio;
    logic        mdio_t;
    logic        init_done;

    // frame decoder state
    logic        mdc_prev;
    logic        t_prev;
    logic [63:0] frame_bits;
    int          run_len;
    int          bit_num;
    int          frames_done;
    int          cyc;
    bit          frame_seen;
    logic [31:0] lfsr_state;
    // {reg_addr, data} per expected frame
    logic [20:0] exp_q[$];

    phy_mgmt_top #(
        .PRESCALE(PRESCALE),
        .PHY_ADDR(PHY_ADDR),
        .INIT_DELAY(INIT_DELAY),
        .DEBOUNCE_RATE(DEBOUNCE_RATE),
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH),
        .DEBOUNCE_WIDTH(DEBOUNCE_WIDTH)
    ) uut (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .btn_i(btn),
        .sw_i(sw),
        .btn_o(btn_db),
        .sw_o(sw_db),
        .mdc_o(mdc),
        .mdio_o(mdio),
        .mdio_t_o(mdio_t),
        .phy_init_done_o(init_done)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_125mhz_int);
        #1;
    endtask

    // four MDIO writes per extended register write
    task automatic build_expected();
        for (int e = 0; e < EXT_WRITE_COUNT; e++) begin
            exp_q.push_back({REG_REGCR, REGCR_ADDR_MODE});
            exp_q.push_back({REG_ADDAR, EXT_WRITES[e].addr});
            exp_q.push_back({REG_REGCR, REGCR_DATA_MODE});
            exp_q.push_back({REG_ADDAR, EXT_WRITES[e].data});
        end
    endtask

    task automatic check_phase();
        assert (run_len == PRESCALE + 1)
            else report_mismatch("mdc phase length", run_len, PRESCALE + 1);
    endtask

    task automatic check_frame();
        logic [20:0] exp;
        assert (bit_num == 64) else report_mismatch("frame bit count", bit_num, 64);
        assert (exp_q.size() > 0) else abort_run("more MDIO frames than expected writes");
        exp = exp_q.pop_front();
        assert (frame_bits[63:32] == 32'hffffffff)
            else report_mismatch("preamble", frame_bits[63:32], 32'hffffffff);
        assert (frame_bits[31:30] == 2'b01) else report_mismatch("start", frame_bits[31:30], 1);
        assert (frame_bits[29:28] == 2'b01) else report_mismatch("opcode", frame_bits[29:28], 1);
        assert (frame_bits[27:23] == 5'(PHY_ADDR))
            else report_mismatch("phy_addr", frame_bits[27:23], PHY_ADDR);
        assert (frame_bits[22:18] == exp[20:16])
            else report_mismatch("reg_addr", frame_bits[22:18], exp[20:16]);
        assert (frame_bits[17:16] == 2'b10) else report_mismatch("turnaround", frame_bits[17:16], 2);
        assert (frame_bits[15:0] == exp[15:0])
            else report_mismatch("data", frame_bits[15:0], exp[15:0]);
        frames_done++;
    endtask

    always @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // sample the bus mid-cycle, away from the clock edge
    always @(negedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            mdc_prev = 1'b0;
            t_prev = 1'b1;
            run_len = 0;
        end else begin
            if (t_prev && !mdio_t) begin
                if (!frame_seen) begin
                    assert (cyc >= INIT_DELAY)
                        else abort_run("first MDIO frame began before the start-up delay");
                end
                assert (!mdc) else abort_run("frame began with mdc high");
                frame_seen = 1'b1;
                run_len = 1;
                bit_num = 0;
                frame_bits = '0;
            end else if (!t_prev && mdio_t) begin
                check_phase();
                check_frame();
            end else if (!mdio_t) begin
                if (mdc == mdc_prev) begin
                    run_len++;
                end else begin
                    check_phase();
                    run_len = 1;
                    // rising mdc edge carries one bit
                    if (mdc) begin
                        frame_bits = {frame_bits[62:0], mdio};
                        bit_num++;
                    end
                end
            end
            mdc_prev = mdc;
            t_prev = mdio_t;
        end
    end

    a_idle_before_first_frame: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        !frame_seen |-> (!mdc && mdio_t && !init_done)
    ) else abort_run("bus activity or init done before the first MDIO frame");

    a_released_after_done: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        init_done |-> mdio_t
    ) else abort_run("MDIO line driven after init done");

    a_done_after_last_frame: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        $rose(init_done) |-> (frames_done == 12)
    ) else abort_run("init done rose before the twelfth frame ended");

    initial begin
        int          waited;
        int          bit_sel;
        logic [31:0] level;
        logic [31:0] pick;
        logic [8:0]  pulsed;
        rst_125mhz_int = 1'b1;
        btn = '0;
        sw = '0;
        frame_seen = 1'b0;
        frames_done = 0;
        bit_num = 0;
        frame_bits = '0;
        lfsr_state = 32'h7c5f6cfd;
        build_expected();
        repeat (2) @(posedge clk_125mhz_int);
        #1;
        rst_125mhz_int = 1'b0;

        waited = 0;
        while (!init_done && waited < DONE_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (init_done) else abort_run("timed out waiting for phy_init_done_o");
        assert (exp_q.size() == 0) else report_mismatch("frames left", exp_q.size(), 0);

        // line must stay released after init
        repeat (500) next_cycle();

        for (int n = 0; n < 8; n++) begin
            draw_bits(9, level);
            {btn, sw} = level[8:0];
            repeat (HOLD_CYCLES) next_cycle();
            assert ({btn_db, sw_db} == level[8:0])
                else report_mismatch("{btn_o, sw_o}", {btn_db, sw_db}, level[8:0]);

            // one-cycle glitch on a single input
            draw_bits(4, pick);
            bit_sel = int'(pick) % 9;
            pulsed = level[8:0];
            pulsed[bit_sel] = ~pulsed[bit_sel];
            {btn, sw} = pulsed;
            next_cycle();
            {btn, sw} = level[8:0];
            repeat (HOLD_CYCLES) begin
                next_cycle();
                assert ({btn_db, sw_db} == level[8:0])
                    else report_mismatch("{btn_o, sw_o} after glitch", {btn_db, sw_db},
                                         level[8:0]);
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* sources.f */
phy_mgmt_pkg.sv
debounce_switch.sv
phy_ext_reg_seq.sv
mdio_master.sv
phy_mgmt_top.sv
tb_phy_mgmt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_phy_mgmt \
    -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
